// ==== Bender.yml ====
package:
  name: rp_drive

sources:
  - design/rpRegPkg.sv
  - design/rpDrivePkg.sv
  - design/rpCs1.sv
  - design/rpDiskAddr.sv
  - design/rpDriveCtrl.sv
  - design/rpDrive.sv
  - target: test
    files:
      - tests/rpDriveTb.sv

// ==== all.f ====
design/rpRegPkg.sv
design/rpDrivePkg.sv
design/rpCs1.sv
design/rpDiskAddr.sv
design/rpDriveCtrl.sv
design/rpDrive.sv
tests/rpDriveTb.sv

// ==== design/rpCs1.sv ====
/*
 * Control/status register 1
 * Latches the function field and issues the start strobe on GO
 */

module rpCs1 (
   input  logic            clk,
   input  logic            rst,
   input  logic            clr,
   input  rpRegPkg::rhData rpDATAI,
   input  logic            cs1Write,
   input  logic            dry,
   output logic            goStrobe,
   output rpRegPkg::rpFunc func,
   output rpRegPkg::rpWord cs1
);

   // Drive can take a new command
   logic accept;

   // Also hold off during the strobe cycle so the controller
   // decodes the function it was started with
   assign accept = cs1Write & dry & ~goStrobe;

   //////////////////////////////////////////////////////////////////////
   // Function field and start strobe
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         func     <= '0;
         goStrobe <= 1'b0;
      end
      else if (clr)
      begin
         func     <= '0;
         goStrobe <= 1'b0;
      end
      else
      begin
         // Function field from bits 5..1
         if (accept)
            func <= rpDATAI[5:1];
         // One clock pulse when GO is written
         goStrobe <= accept & rpDATAI[0];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // CS1 word
   //////////////////////////////////////////////////////////////////////

   // Data valid in bit 11 always set on this drive
   // GO reads back as busy
   assign cs1 = {4'b0, 1'b1, 5'b0, func, ~dry};

endmodule

// ==== design/rpDiskAddr.sv ====
/*
 * Desired sector/track (DA) and desired cylinder (DC) registers
 * Writes only while ready, cleared by preset, checked against the pack
 */

module rpDiskAddr (
   input  logic            clk,
   input  logic            rst,
   input  logic            clr,
   input  rpRegPkg::rhData rpDATAI,
   input  logic            daWrite,
   input  logic            dcWrite,
   input  logic            dry,
   input  logic            presetAddr,
   output rpRegPkg::rpAddr desired,
   output logic            addrValid,
   output rpRegPkg::rpWord daWord,
   output rpRegPkg::rpWord dcWord
);

   // Per-field range checks
   logic sectorOk;
   logic trackOk;
   logic cylOk;

   //////////////////////////////////////////////////////////////////////
   // Address registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         desired <= '0;
      end
      else if (clr)
      begin
         desired <= '0;
      end
      else if (presetAddr)
      begin
         // Preset returns to sector 0, track 0, cylinder 0
         desired <= '0;
      end
      else
      begin
         // DA holds track in 12..8 and sector in 4..0
         if (daWrite & dry)
         begin
            desired.track  <= rpDATAI[12:8];
            desired.sector <= rpDATAI[4:0];
         end
         // DC holds the cylinder in 9..0
         if (dcWrite & dry)
            desired.cyl <= rpDATAI[9:0];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Geometry check
   //////////////////////////////////////////////////////////////////////

   assign sectorOk = desired.sector <= rpDrivePkg::maxSector;
   assign trackOk  = desired.track <= rpDrivePkg::maxTrack;
   assign cylOk    = desired.cyl <= rpDrivePkg::maxCyl;

   // Any field out of range makes the seek invalid
   assign addrValid = sectorOk & trackOk & cylOk;

   //////////////////////////////////////////////////////////////////////
   // Register words
   //////////////////////////////////////////////////////////////////////

   assign daWord = {3'b0, desired.track, 3'b0, desired.sector};
   assign dcWord = {6'b0, desired.cyl};

endmodule

// ==== design/rpDrive.sv ====
/*
 * RP disk drive register set and seek control
 * Host register decode and readback around CS1, address and controller
 */

module rpDrive (
   input  logic             clk,
   input  logic             rst,
   input  logic             clr,
   input  rpRegPkg::regAddr regSel,
   input  logic             regWrite,
   input  rpRegPkg::rhData  rpDATAI,
   output rpRegPkg::rpWord  rpDATAO,
   output logic             ata
);

   // Per-register write strobes
   logic cs1Write;
   logic daWrite;
   logic dcWrite;

   // Command path
   logic            goStrobe;
   rpRegPkg::rpFunc func;
   logic            dry;
   logic            presetAddr;

   // Address path
   rpRegPkg::rpAddr desired;
   logic            addrValid;

   // Controller state seen by the host
   rpRegPkg::rpStatus status;
   rpRegPkg::rpErrors errors;
   rpRegPkg::rpCyl    curCyl;

   // Register words for readback
   rpRegPkg::rpWord cs1Word;
   rpRegPkg::rpWord dsWord;
   rpRegPkg::rpWord er1Word;
   rpRegPkg::rpWord daWord;
   rpRegPkg::rpWord dcWord;
   rpRegPkg::rpWord ccWord;

   //////////////////////////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////////////////////////

   assign cs1Write = regWrite & (regSel == rpRegPkg::addrCs1);
   assign daWrite  = regWrite & (regSel == rpRegPkg::addrDa);
   assign dcWrite  = regWrite & (regSel == rpRegPkg::addrDc);

   //////////////////////////////////////////////////////////////////////
   // Register blocks
   //////////////////////////////////////////////////////////////////////

   rpCs1 i_cs1 (
      .clk(clk), .rst(rst), .clr(clr), .rpDATAI(rpDATAI), .cs1Write(cs1Write),
      .dry(dry), .goStrobe(goStrobe), .func(func), .cs1(cs1Word)
   );

   rpDiskAddr i_diskAddr (
      .clk(clk), .rst(rst), .clr(clr), .rpDATAI(rpDATAI), .daWrite(daWrite),
      .dcWrite(dcWrite), .dry(dry), .presetAddr(presetAddr), .desired(desired),
      .addrValid(addrValid), .daWord(daWord), .dcWord(dcWord)
   );

   rpDriveCtrl i_driveCtrl (
      .clk(clk), .rst(rst), .clr(clr), .goStrobe(goStrobe), .func(func),
      .desired(desired), .addrValid(addrValid), .dry(dry), .presetAddr(presetAddr),
      .status(status), .errors(errors), .curCyl(curCyl), .dsWord(dsWord),
      .er1Word(er1Word), .ccWord(ccWord)
   );

   //////////////////////////////////////////////////////////////////////
   // Read multiplexer
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (regSel)
         rpRegPkg::addrCs1: rpDATAO = cs1Word;
         rpRegPkg::addrDs:  rpDATAO = dsWord;
         rpRegPkg::addrEr1: rpDATAO = er1Word;
         rpRegPkg::addrDa:  rpDATAO = daWord;
         rpRegPkg::addrDc:  rpDATAO = dcWord;
         rpRegPkg::addrCc:  rpDATAO = ccWord;
         // Unmapped registers read as zero
         default:           rpDATAO = '0;
      endcase
   end

   // Attention to the RH controller
   assign ata = status.ata;

endmodule

// ==== design/rpDriveCtrl.sv ====
/*
 * Drive function controller
 * Executes started functions, times seeks, keeps CC, status and errors
 */

module rpDriveCtrl (
   input  logic              clk,
   input  logic              rst,
   input  logic              clr,
   input  logic              goStrobe,
   input  rpRegPkg::rpFunc   func,
   input  rpRegPkg::rpAddr   desired,
   input  logic              addrValid,
   output logic              dry,
   output logic              presetAddr,
   output rpRegPkg::rpStatus status,
   output rpRegPkg::rpErrors errors,
   output rpRegPkg::rpCyl    curCyl,
   output rpRegPkg::rpWord   dsWord,
   output rpRegPkg::rpWord   er1Word,
   output rpRegPkg::rpWord   ccWord
);

   rpDrivePkg::rpCtrlState state;
   rpDrivePkg::rpFuncCode  funcCode;

   // Attention and volume valid flops
   logic ata;
   logic vv;

   // Seek datapath
   rpRegPkg::rpCyl       seekTarget;
   rpRegPkg::rpCyl       distance;
   rpRegPkg::rpCyl       targetCyl;
   rpDrivePkg::rpSeekCnt seekLoad;
   rpDrivePkg::rpSeekCnt seekCnt;

   assign funcCode = rpDrivePkg::rpFuncCode'(func);

   //////////////////////////////////////////////////////////////////////
   // Seek distance and busy time
   //////////////////////////////////////////////////////////////////////

   // Recalibrate always heads for cylinder 0
   assign seekTarget = (funcCode == rpDrivePkg::funRecal) ? '0 : desired.cyl;

   assign distance = (seekTarget > curCyl) ? seekTarget - curCyl : curCyl - seekTarget;

   // One less than the busy time, the zero count is the last seek clock
   assign seekLoad = rpDrivePkg::rpSeekCnt'(rpDrivePkg::seekSettle - 1)
                   + rpDrivePkg::rpSeekCnt'(distance);

   always_ff @(posedge clk)
   begin
      if (state == rpDrivePkg::execute)
      begin
         seekCnt   <= seekLoad;
         targetCyl <= seekTarget;
      end
      else if (state == rpDrivePkg::seeking)
         seekCnt <= seekCnt - 1'b1;
   end

   //////////////////////////////////////////////////////////////////////
   // Function FSM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state      <= rpDrivePkg::idle;
         dry        <= 1'b1;
         presetAddr <= 1'b0;
         ata        <= 1'b0;
         vv         <= 1'b0;
         errors     <= '0;
         curCyl     <= '0;
      end
      else if (clr)
      begin
         state      <= rpDrivePkg::idle;
         dry        <= 1'b1;
         presetAddr <= 1'b0;
         ata        <= 1'b0;
         vv         <= 1'b0;
         errors     <= '0;
         curCyl     <= '0;
      end
      else
      begin
         // Preset strobe lasts a single clock
         presetAddr <= 1'b0;
         case (state)
            rpDrivePkg::idle:
               if (goStrobe)
               begin
                  state <= rpDrivePkg::execute;
                  dry   <= 1'b0;
               end
            rpDrivePkg::execute:
            begin
               // Most functions finish on the next clock
               state <= rpDrivePkg::done;
               case (funcCode)
                  rpDrivePkg::funNop:
                     ;
                  rpDrivePkg::funSeek:
                     if (addrValid)
                        state <= rpDrivePkg::seeking;
                     else
                     begin
                        // Bad address, head does not move
                        errors.iae <= 1'b1;
                        ata        <= 1'b1;
                     end
                  rpDrivePkg::funRecal:
                     state <= rpDrivePkg::seeking;
                  rpDrivePkg::funDrvClr:
                  begin
                     errors <= '0;
                     ata    <= 1'b0;
                  end
                  rpDrivePkg::funPreset:
                  begin
                     presetAddr <= 1'b1;
                     vv         <= 1'b1;
                  end
                  rpDrivePkg::funPackAck:
                     vv <= 1'b1;
                  default:
                  begin
                     // Transfer and other unsupported codes
                     errors.ilf <= 1'b1;
                     ata        <= 1'b1;
                  end
               endcase
            end
            rpDrivePkg::seeking:
               if (seekCnt == '0)
               begin
                  // Head arrives on cylinder
                  curCyl <= targetCyl;
                  ata    <= 1'b1;
                  state  <= rpDrivePkg::done;
               end
            rpDrivePkg::done:
            begin
               dry   <= 1'b1;
               state <= rpDrivePkg::idle;
            end
            default:
               state <= rpDrivePkg::idle;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Status and register words
   //////////////////////////////////////////////////////////////////////

   // Pack is always mounted
   assign status = '{ata: ata, err: errors.ilf | errors.iae, mol: 1'b1, dry: dry, vv: vv};

   // DS layout: ATA 15, ERR 14, MOL 12, DRY 7, VV 6
   assign dsWord = {status.ata, status.err, 1'b0, status.mol, 4'b0,
                    status.dry, status.vv, 6'b0};

   // ER1 layout: IAE 10, ILF 0
   assign er1Word = {5'b0, errors.iae, 9'b0, errors.ilf};

   assign ccWord = {6'b0, curCyl};

endmodule

// ==== design/rpDrivePkg.sv ====
/*
 * RP drive behavior constants
 * Function codes, pack geometry, seek timing and controller states
 */

package rpDrivePkg;

   //////////////////////////////////////////////////////////////////////
   // Function codes
   //////////////////////////////////////////////////////////////////////

   // Only the non-transfer functions are kept
   typedef enum logic [4:0] {
      funNop     = 5'd0,
      funSeek    = 5'd2,
      funRecal   = 5'd3,
      funDrvClr  = 5'd4,
      funPreset  = 5'd8,
      funPackAck = 5'd9
   } rpFuncCode;

   //////////////////////////////////////////////////////////////////////
   // Pack geometry
   //////////////////////////////////////////////////////////////////////

   // Highest legal values, inclusive
   localparam rpRegPkg::rpSector maxSector = 5'd21;
   localparam rpRegPkg::rpTrack  maxTrack  = 5'd18;
   localparam rpRegPkg::rpCyl    maxCyl    = 10'd410;

   //////////////////////////////////////////////////////////////////////
   // Seek timing
   //////////////////////////////////////////////////////////////////////

   // Fixed overhead of every head movement, in clocks
   localparam int seekSettle = 8;

   // Busy counter, wide enough for seekSettle + maxCyl
   localparam int seekCntWidth = 10;
   typedef logic [seekCntWidth-1:0] rpSeekCnt;

   //////////////////////////////////////////////////////////////////////
   // Controller states
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      idle,
      execute,
      seeking,
      done
   } rpCtrlState;

endpackage

// ==== design/rpRegPkg.sv ====
/*
 * RP drive register map and field types
 * Host word, register word, address fields, DS status and ER1 error bits
 */

package rpRegPkg;

   //////////////////////////////////////////////////////////////////////
   // Word widths
   //////////////////////////////////////////////////////////////////////

   // Massbus data path from the RH controller
   localparam int rhWidth = 36;
   // Drive registers are 16 bits
   localparam int wordWidth = 16;
   localparam int addrWidth = 5;

   typedef logic [rhWidth-1:0]   rhData;
   typedef logic [wordWidth-1:0] rpWord;
   typedef logic [addrWidth-1:0] regAddr;

   //////////////////////////////////////////////////////////////////////
   // Register map
   //////////////////////////////////////////////////////////////////////

   localparam regAddr addrCs1 = 5'd0;
   localparam regAddr addrDs  = 5'd1;
   localparam regAddr addrEr1 = 5'd2;
   localparam regAddr addrDa  = 5'd5;
   localparam regAddr addrDc  = 5'd10;
   localparam regAddr addrCc  = 5'd11;

   //////////////////////////////////////////////////////////////////////
   // Field types
   //////////////////////////////////////////////////////////////////////

   // CS1 bits 5..1
   typedef logic [4:0] rpFunc;
   typedef logic [9:0] rpCyl;
   typedef logic [4:0] rpTrack;
   typedef logic [4:0] rpSector;

   // Desired disk address, DC plus DA
   typedef struct packed {
      rpCyl    cyl;
      rpTrack  track;
      rpSector sector;
   } rpAddr;

   // DS bits 15, 14, 12, 7 and 6
   typedef struct packed {
      logic ata;
      logic err;
      logic mol;
      logic dry;
      logic vv;
   } rpStatus;

   // ER1 bit 0 (ILF) and bit 10 (IAE)
   typedef struct packed {
      logic ilf;
      logic iae;
   } rpErrors;

endpackage

// ==== tests/rpDriveTb.sv ====
/*
 * Table-driven testbench for the RP drive register set
 * Covers reset state, function start, seeks, errors, preset and drive init
 */

module rpDriveTb;

   typedef enum logic [1:0] {opWrite, opRead, opWaitReady, opClr} tbOp;

   // One table row
   typedef struct packed {
      tbOp              op;
      rpRegPkg::regAddr addr;
      rpRegPkg::rhData  data;
      rpRegPkg::rpWord  expVal;
      rpRegPkg::rpWord  mask;
   } tbStep;

   localparam int rstCycles = 8;
   localparam int waitBound = rpDrivePkg::seekSettle + rpDrivePkg::maxCyl + 8;
   localparam logic [31:0] seed = 32'he45bd9f6;

   // Register bit patterns
   localparam rpRegPkg::rpWord allBits = 16'hFFFF;
   localparam rpRegPkg::rpWord cs1Dva  = 16'h0800;
   localparam rpRegPkg::rpWord dsAta   = 16'h8000;
   localparam rpRegPkg::rpWord dsErr   = 16'h4000;
   localparam rpRegPkg::rpWord dsMol   = 16'h1000;
   localparam rpRegPkg::rpWord dsDry   = 16'h0080;
   localparam rpRegPkg::rpWord dsVv    = 16'h0040;
   localparam rpRegPkg::rpWord er1Iae  = 16'h0400;
   localparam rpRegPkg::rpWord er1Ilf  = 16'h0001;

   logic             clk;
   logic             rst;
   logic             clr;
   rpRegPkg::regAddr regSel;
   logic             regWrite;
   rpRegPkg::rhData  rpDATAI;
   rpRegPkg::rpWord  rpDATAO;
   logic             ata;

   tbStep       steps[$];
   logic [31:0] rngState;
   bit          stepsBuilt;

   rpDrive i_dut (
      .clk(clk), .rst(rst), .clr(clr), .regSel(regSel), .regWrite(regWrite),
      .rpDATAI(rpDATAI), .rpDATAO(rpDATAO), .ata(ata)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Host data for a CS1 write, function in 5..1, GO in 0
   function automatic rpRegPkg::rhData cs1Cmd(input logic [4:0] fn, input logic go);
      return {30'b0, fn, go};
   endfunction

   // Expected CS1 readback, data valid always set
   function automatic rpRegPkg::rpWord cs1Read(input logic [4:0] fn, input logic go);
      return cs1Dva | rpRegPkg::rpWord'({fn, go});
   endfunction

   function automatic string regName(input rpRegPkg::regAddr addr);
      case (addr)
         rpRegPkg::addrCs1: return "CS1";
         rpRegPkg::addrDs:  return "DS";
         rpRegPkg::addrEr1: return "ER1";
         rpRegPkg::addrDa:  return "DA";
         rpRegPkg::addrDc:  return "DC";
         rpRegPkg::addrCc:  return "CC";
         default:           return "unmapped";
      endcase
   endfunction

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic stopOnError();
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped at first error");
   endtask

   //////////////////////////////////////////////////////////////////////
   // Table construction
   //////////////////////////////////////////////////////////////////////

   task automatic addStep(input tbOp op, input rpRegPkg::regAddr addr,
                          input rpRegPkg::rhData data, input rpRegPkg::rpWord expVal,
                          input rpRegPkg::rpWord mask);
      tbStep s;
      s.op     = op;
      s.addr   = addr;
      s.data   = data;
      s.expVal = expVal;
      s.mask   = mask;
      steps.push_back(s);
   endtask

   task automatic writeStep(input rpRegPkg::regAddr addr, input rpRegPkg::rhData data);
      addStep(opWrite, addr, data, '0, '0);
   endtask

   task automatic checkStep(input rpRegPkg::regAddr addr, input rpRegPkg::rpWord expVal,
                            input rpRegPkg::rpWord mask);
      addStep(opRead, addr, '0, expVal, mask);
   endtask

   task automatic readyStep();
      addStep(opWaitReady, rpRegPkg::addrDs, '0, '0, '0);
   endtask

   // Full post-reset register image
   task automatic resetState();
      checkStep(rpRegPkg::addrCs1, cs1Dva, allBits);
      checkStep(rpRegPkg::addrDs, dsMol | dsDry, allBits);
      checkStep(rpRegPkg::addrEr1, '0, allBits);
      checkStep(rpRegPkg::addrDa, '0, allBits);
      checkStep(rpRegPkg::addrDc, '0, allBits);
      checkStep(rpRegPkg::addrCc, '0, allBits);
   endtask

   task automatic clearDrive();
      writeStep(rpRegPkg::addrCs1, cs1Cmd(rpDrivePkg::funDrvClr, 1'b1));
      readyStep();
   endtask

   task automatic buildSteps();
      rpRegPkg::rpCyl  cyl;
      rpRegPkg::rhData badDa;
      rpRegPkg::rhData badDc;
      resetState();
      // Function field without GO, no start
      writeStep(rpRegPkg::addrCs1, cs1Cmd(rpDrivePkg::funSeek, 1'b0));
      checkStep(rpRegPkg::addrCs1, cs1Read(rpDrivePkg::funSeek, 1'b0), allBits);
      checkStep(rpRegPkg::addrDs, dsMol | dsDry, allBits);
      // Pack acknowledge
      writeStep(rpRegPkg::addrCs1, cs1Cmd(rpDrivePkg::funPackAck, 1'b1));
      readyStep();
      checkStep(rpRegPkg::addrDs, dsMol | dsDry | dsVv, allBits);
      cyl = '0;
      for (int i = 0; i < 2; i++)
      begin
         rngState = xorshift32(rngState);
         cyl = rpRegPkg::rpCyl'(rngState % (rpDrivePkg::maxCyl + 1));
         writeStep(rpRegPkg::addrDa, 36'h050A);
         writeStep(rpRegPkg::addrDc, 36'(cyl));
         writeStep(rpRegPkg::addrCs1, cs1Cmd(rpDrivePkg::funSeek, 1'b1));
         // Busy, GO reads back and late writes drop
         checkStep(rpRegPkg::addrCs1, cs1Read(rpDrivePkg::funSeek, 1'b1), allBits);
         writeStep(rpRegPkg::addrDc, 36'(rpRegPkg::rpCyl'(~cyl)));
         writeStep(rpRegPkg::addrCs1, cs1Cmd(rpDrivePkg::funDrvClr, 1'b1));
         readyStep();
         checkStep(rpRegPkg::addrCs1, cs1Read(rpDrivePkg::funSeek, 1'b0), allBits);
         checkStep(rpRegPkg::addrDc, 16'(cyl), allBits);
         checkStep(rpRegPkg::addrCc, 16'(cyl), allBits);
         checkStep(rpRegPkg::addrDs, dsAta | dsMol | dsDry | dsVv, allBits);
         clearDrive();
         checkStep(rpRegPkg::addrDs, dsMol | dsDry | dsVv, allBits);
      end
      // Sector 22, track 19, then cylinder 411
      for (int i = 0; i < 3; i++)
      begin
         badDa = (i == 0) ? 36'h0016 : (i == 1) ? 36'h1300 : 36'h0;
         // Legal cylinder away from the head, a wrong move shows in CC
         badDc = (i == 2) ? 36'd411 : (cyl == '0) ? 36'd1 : 36'd0;
         writeStep(rpRegPkg::addrDa, badDa);
         writeStep(rpRegPkg::addrDc, badDc);
         writeStep(rpRegPkg::addrCs1, cs1Cmd(rpDrivePkg::funSeek, 1'b1));
         readyStep();
         checkStep(rpRegPkg::addrEr1, er1Iae, allBits);
         checkStep(rpRegPkg::addrDs, dsAta | dsErr | dsMol | dsDry | dsVv, allBits);
         checkStep(rpRegPkg::addrCc, 16'(cyl), allBits);
         clearDrive();
      end
      // Undefined function code on a clean drive
      writeStep(rpRegPkg::addrCs1, cs1Cmd(5'd12, 1'b1));
      readyStep();
      checkStep(rpRegPkg::addrEr1, er1Ilf, allBits);
      checkStep(rpRegPkg::addrDs, dsAta | dsErr | dsMol | dsDry | dsVv, allBits);
      clearDrive();
      checkStep(rpRegPkg::addrEr1, '0, allBits);
      checkStep(rpRegPkg::addrDs, dsMol | dsDry | dsVv, allBits);
      // Recalibrate
      writeStep(rpRegPkg::addrCs1, cs1Cmd(rpDrivePkg::funRecal, 1'b1));
      readyStep();
      checkStep(rpRegPkg::addrCc, '0, allBits);
      checkStep(rpRegPkg::addrDs, dsAta | dsMol | dsDry | dsVv, allBits);
      // Preset
      writeStep(rpRegPkg::addrDa, 36'h050A);
      writeStep(rpRegPkg::addrDc, 36'd100);
      checkStep(rpRegPkg::addrDa, 16'h050A, allBits);
      checkStep(rpRegPkg::addrDc, 16'd100, allBits);
      writeStep(rpRegPkg::addrCs1, cs1Cmd(rpDrivePkg::funPreset, 1'b1));
      readyStep();
      checkStep(rpRegPkg::addrDa, '0, allBits);
      checkStep(rpRegPkg::addrDc, '0, allBits);
      checkStep(rpRegPkg::addrDs, dsDry | dsVv, dsDry | dsVv);
      // Dirty every register, then drive init
      writeStep(rpRegPkg::addrDc, 36'd7);
      writeStep(rpRegPkg::addrCs1, cs1Cmd(rpDrivePkg::funSeek, 1'b1));
      readyStep();
      writeStep(rpRegPkg::addrDa, 36'h0203);
      writeStep(rpRegPkg::addrCs1, cs1Cmd(5'd12, 1'b1));
      readyStep();
      checkStep(rpRegPkg::addrCc, 16'd7, allBits);
      checkStep(rpRegPkg::addrDa, 16'h0203, allBits);
      checkStep(rpRegPkg::addrEr1, er1Ilf, allBits);
      addStep(opClr, rpRegPkg::addrCs1, '0, '0, '0);
      resetState();
   endtask

   //////////////////////////////////////////////////////////////////////
   // Table execution
   //////////////////////////////////////////////////////////////////////

   task automatic checkRead(input tbStep s);
      assert ((rpDATAO & s.mask) == (s.expVal & s.mask))
      else
      begin
         $display("[FAIL] %0t: %s read %h, expected %h mask %h", $time, regName(s.addr),
                  rpDATAO, s.expVal, s.mask);
         stopOnError();
      end
      // Attention line follows DS bit 15
      if (s.addr == rpRegPkg::addrDs && s.mask[15])
         assert (ata == s.expVal[15])
         else
         begin
            $display("[FAIL] %0t: ata is %b, expected %b", $time, ata, s.expVal[15]);
            stopOnError();
         end
   endtask

   task automatic waitReady();
      int polls;
      polls = 0;
      regWrite = 1'b0;
      regSel = rpRegPkg::addrDs;
      #4;
      while ((rpDATAO & dsDry) == '0)
      begin
         if (polls == waitBound)
         begin
            $display("Drive never became ready within %0d cycles", waitBound);
            stopOnError();
         end
         polls++;
         tick();
         #4;
      end
      tick();
   endtask

   task automatic runStep(input tbStep s);
      case (s.op)
         opWrite:
         begin
            regSel   = s.addr;
            rpDATAI  = s.data;
            regWrite = 1'b1;
            tick();
            regWrite = 1'b0;
            // Extra clock lets a started function drop ready
            tick();
         end
         opRead:
         begin
            regSel = s.addr;
            #4;
            checkRead(s);
            tick();
         end
         opWaitReady:
            waitReady();
         default:
         begin
            clr = 1'b1;
            tick();
            clr = 1'b0;
         end
      endcase
   endtask

   // Watchdog sized from the table
   initial
   begin
      wait (stepsBuilt);
      #((rstCycles + steps.size() * waitBound) * 10);
      $display("Timeout, the test table did not finish in time");
      stopOnError();
   end

   initial
   begin
      rst        = 1'b1;
      clr        = 1'b0;
      regSel     = '0;
      regWrite   = 1'b0;
      rpDATAI    = '0;
      rngState   = seed;
      stepsBuilt = 1'b0;
      buildSteps();
      stepsBuilt = 1'b1;
      repeat (rstCycles) @(posedge clk);
      #1;
      rst = 1'b0;
      foreach (steps[i])
         runStep(steps[i]);
      $display("STATUS: PASS");
      $finish;
   end

endmodule
